// File: flist.f
common/sensor_pkg.sv
common/i2c_req_if.sv
i2c/i2c_master.sv
verilog/lux_convert.sv
verilog/sensor_poller.sv
verilog/sensor_hub_top.sv
tb/i2c_sensor_model.sv
tb/tb_sensor_hub.sv

// File: Bender.yml
package:
  name: sensor_hub

sources:
  - common/sensor_pkg.sv
  - common/i2c_req_if.sv
  - i2c/i2c_master.sv
  - verilog/lux_convert.sv
  - verilog/sensor_poller.sv
  - verilog/sensor_hub_top.sv
  - target: test
    files:
      - tb/i2c_sensor_model.sv
      - tb/tb_sensor_hub.sv

// File: tb/tb_sensor_hub.sv
`timescale 1ns/1ps

module tb_sensor_hub;

	// Poll order, solar first and west last
	localparam logic [7:0][6:0] ADDRS = {
		7'h47, 7'h46, 7'h45, 7'h44, 7'h4B, 7'h4A, 7'h49, 7'h48
	};
	localparam int TIMEOUT = 10000; // Clocks allowed per sweep

	logic clk;
	logic rst;
	logic scl;
	logic sda_oe;
	logic sda_in;
	logic model_pull;
	logic [7:0][15:0] words; // Words the model serves, by poll index
	logic [3:0][8:0] celsius;
	logic [3:0][15:0] lux; // North, east, south, west
	logic [7:0] sensor_fault;
	logic sweep_done;
	int seed = 18149;
	int checks = 0;
	int errors = 0;
	int starts = 0; // Start conditions since the last sweep
	bit in_frame = 1'b0; // Between a start and its stop
	bit timed_out = 1'b0;

	assign sda_in = !sda_oe && !model_pull; // Open-drain wired AND

	sensor_hub_top i_dut (
		.clk(clk),
		.rst(rst),
		.scl(scl),
		.sda_oe(sda_oe),
		.sda_in(sda_in),
		.solar_celsius(celsius[0]),
		.greenhouse_celsius(celsius[1]),
		.ambient_celsius(celsius[2]),
		.geothermal_celsius(celsius[3]),
		.n_lux(lux[0]),
		.e_lux(lux[1]),
		.s_lux(lux[2]),
		.w_lux(lux[3]),
		.sensor_fault(sensor_fault),
		.sweep_done(sweep_done)
	);

	// East sensor left off the bus
	i2c_sensor_model #(.ADDRS(ADDRS), .PRESENT(8'hDF)) i_model (
		.scl(scl),
		.sda(sda_in),
		.words(words),
		.pull(model_pull)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Light word scale is 0.01 lux times two to the exponent
	function automatic logic [15:0] expect_lux(logic [15:0] w);
		longint v;
		v = longint'(w[11:0]) << w[15:12];
		v = v / 100;
		return (v > 65535) ? 16'hFFFF : v[15:0];
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("** Error: %s expected %0h actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic load_words();
		logic [7:0][15:0] w;
		for (int i = 0; i < 8; i++)
			w[i] = $random(seed);
		w[6][15:11] = 5'b11111; // South at exponent 15, forces saturation
		words <= w;
	endtask

	task automatic wait_sweep();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (sweep_done !== 1'b1 && n < TIMEOUT);
		if (sweep_done !== 1'b1)
		begin
			$display("Timed out waiting for sweep_done");
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_sweep(string tag);
		for (int i = 0; i < 4; i++)
			check_value($sformatf("%s celsius %0d", tag, i), words[i][15:7], celsius[i]);
		for (int i = 0; i < 4; i++)
			check_value($sformatf("%s lux %0d", tag, i),
				(i == 1) ? 16'h0 : expect_lux(words[i + 4]), lux[i]); // East stays 0
		check_value({tag, " fault"}, 8'h20, sensor_fault);
		check_value({tag, " starts"}, 8, starts);
		starts = 0;
	endtask

	// Every SDA move under a high SCL must alternate start and stop
	always @(sda_in)
	begin
		if (rst === 1'b0 && scl === 1'b1)
		begin
			if (sda_in === 1'b0)
			begin
				assert (!in_frame)
				else
				begin
					$display("SDA fell under high SCL inside an open frame");
					errors++;
				end
				in_frame = 1'b1;
				starts++;
			end
			else
			begin
				assert (in_frame)
				else
				begin
					$display("SDA rose under high SCL with no frame open");
					errors++;
				end
				in_frame = 1'b0;
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		words = '0;
		@(posedge clk);
		load_words();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("reset scl", 1, scl);
		check_value("reset sda_oe", 0, sda_oe);
		check_value("reset sweep_done", 0, sweep_done);
		check_value("reset fault", 0, sensor_fault);
		for (int i = 0; i < 4; i++)
		begin
			check_value($sformatf("reset celsius %0d", i), 0, celsius[i]);
			check_value($sformatf("reset lux %0d", i), 0, lux[i]);
		end
		wait_sweep();
		if (!timed_out)
		begin
			check_sweep("sweep 1");
			@(posedge clk);
			load_words(); // Fresh words for the second sweep
			wait_sweep();
		end
		if (!timed_out)
			check_sweep("sweep 2");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tb/i2c_sensor_model.sv
`timescale 1ns/1ps

module i2c_sensor_model #(
	parameter logic [7:0][6:0] ADDRS = '0, // Bus address per slot
	parameter logic [7:0] PRESENT = 8'hFF // Slots that answer
) (
	input logic scl,
	input logic sda, // Resolved line
	input logic [7:0][15:0] words, // Word served per slot
	output logic pull // 1 pulls SDA low
);

	int edges; // SCL rises since the last start or stop
	int slot; // Bit slot about to begin
	logic [7:0] addr_byte; // Address and R/W as received
	logic hit; // Addressed slot is present
	logic [15:0] cur; // Word being served

	initial
	begin
		edges = 0;
		slot = 0;
		addr_byte = '0;
		hit = 1'b0;
		cur = '0;
		pull = 1'b0;
	end

	// Start or stop, SDA moving under a high SCL
	always @(sda)
	begin
		if (scl === 1'b1)
		begin
			edges = 0;
			hit = 1'b0;
		end
	end

	always @(posedge scl)
	begin
		edges = edges + 1;
		if (edges <= 8)
			addr_byte = {addr_byte[6:0], sda}; // MSB first
	end

	// SDA changes only while SCL is low
	always @(negedge scl)
	begin
		slot = edges + 1;
		if (slot == 9)
		begin
			for (int i = 0; i < 8; i++)
			begin
				if (PRESENT[i] && addr_byte == {ADDRS[i], 1'b1})
				begin
					hit = 1'b1;
					cur = words[i]; // Held for the whole read
				end
			end
			pull = hit; // ACK only a present address
		end
		else if (hit && slot >= 10 && slot <= 17)
			pull = !cur[25 - slot]; // Upper byte, MSB first
		else if (hit && slot >= 19 && slot <= 26)
			pull = !cur[26 - slot]; // Lower byte
		else
			pull = 1'b0; // Released for master ACK and stop
	end

endmodule

// File: verilog/sensor_hub_top.sv
`timescale 1ns/1ps

module sensor_hub_top (
	input logic clk,
	input logic rst,
	output logic scl,
	output logic sda_oe, // 1 pulls SDA low
	input logic sda_in, // Resolved bus line
	output logic [8:0] solar_celsius,
	output logic [8:0] greenhouse_celsius,
	output logic [8:0] ambient_celsius,
	output logic [8:0] geothermal_celsius,
	output logic [15:0] n_lux,
	output logic [15:0] e_lux,
	output logic [15:0] s_lux,
	output logic [15:0] w_lux,
	output logic [7:0] sensor_fault,
	output logic sweep_done
);

	i2c_req_if req (); // Poller to master request path

	sensor_poller i_poller (
		.clk(clk),
		.rst(rst),
		.req(req.poller),
		.solar_celsius(solar_celsius),
		.greenhouse_celsius(greenhouse_celsius),
		.ambient_celsius(ambient_celsius),
		.geothermal_celsius(geothermal_celsius),
		.n_lux(n_lux),
		.e_lux(e_lux),
		.s_lux(s_lux),
		.w_lux(w_lux),
		.sensor_fault(sensor_fault),
		.sweep_done(sweep_done)
	);

	i2c_master i_master (
		.clk(clk),
		.rst(rst),
		.req(req.master),
		.scl(scl),
		.sda_oe(sda_oe),
		.sda_in(sda_in)
	);

endmodule

// File: verilog/sensor_poller.sv
`timescale 1ns/1ps

module sensor_poller
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	i2c_req_if.poller req,
	output logic [8:0] solar_celsius,
	output logic [8:0] greenhouse_celsius,
	output logic [8:0] ambient_celsius,
	output logic [8:0] geothermal_celsius,
	output logic [15:0] n_lux,
	output logic [15:0] e_lux,
	output logic [15:0] s_lux,
	output logic [15:0] w_lux,
	output logic [NUM_SENSORS-1:0] sensor_fault, // Bit per poll index
	output logic sweep_done
);

	poll_idx_t idx; // Sensor being read
	logic busy; // Set after the first request
	logic done; // Read finished this cycle
	logic last_idx; // West sensor in flight
	sensor_word_u word;
	logic [15:0] lux_val;
	logic [8:0] celsius_q [NUM_TEMP];
	logic [15:0] lux_q [NUM_SENSORS-NUM_TEMP];

	assign word = req.read_data;
	assign req.addr = sensor_addr[idx]; // Held until idx moves on
	assign last_idx = (idx == poll_idx_t'(NUM_SENSORS - 1));

	// Ready seen again once the request pulse is gone
	assign done = busy && !req.start && req.ready;

	lux_convert i_lux (
		.word(word),
		.lux(lux_val)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			idx <= '0;
			busy <= 1'b0;
			req.start <= 1'b0;
			sweep_done <= 1'b0;
			sensor_fault <= '0;
			for (int i = 0; i < NUM_TEMP; i++)
				celsius_q[i] <= '0;
			for (int i = 0; i < NUM_SENSORS - NUM_TEMP; i++)
				lux_q[i] <= '0;
		end
		else
		begin
			req.start <= (!busy && req.ready) || done; // Next read right away
			sweep_done <= done && last_idx;
			if (req.ready)
				busy <= 1'b1;
			if (done)
			begin
				idx <= last_idx ? '0 : idx + 1'b1;
				if (req.nack)
					sensor_fault[idx] <= 1'b1; // Output keeps its old value
				else
				begin
					sensor_fault[idx] <= 1'b0;
					if (idx < NUM_TEMP)
						celsius_q[idx[1:0]] <= word.temp.celsius;
					else
						lux_q[idx[1:0]] <= lux_val; // Light sensors 4 to 7
				end
			end
		end
	end

	assign solar_celsius = celsius_q[0];
	assign greenhouse_celsius = celsius_q[1];
	assign ambient_celsius = celsius_q[2];
	assign geothermal_celsius = celsius_q[3];
	assign n_lux = lux_q[0];
	assign e_lux = lux_q[1];
	assign s_lux = lux_q[2];
	assign w_lux = lux_q[3];

	// Handshake with the master, never request while it is busy
	assert property (@(posedge clk) disable iff (rst)
		req.start |-> req.ready);

endmodule

// File: verilog/lux_convert.sv
`timescale 1ns/1ps

module lux_convert
	import sensor_pkg::*;
(
	input sensor_word_u word,
	output logic [15:0] lux
);

	logic [26:0] scaled; // Mantissa times two to the exponent, 0.01 lux units
	logic [26:0] whole; // Whole lux before saturation

	assign scaled = {15'd0, word.light.mantissa} << word.light.exponent;
	assign whole = scaled / 27'd100;

	// Clip large exponents to full scale
	assign lux = (|whole[26:16]) ? 16'hFFFF : whole[15:0];

endmodule

// File: i2c/i2c_master.sv
`timescale 1ns/1ps

module i2c_master
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	i2c_req_if.master req,
	output logic scl,
	output logic sda_oe, // 1 pulls SDA low
	input logic sda_in // Resolved line level
);

	logic [2:0] state; // Current bus phase
	logic [$clog2(QUARTER_BIT)-1:0] cyc; // Clock count inside a quarter
	logic [1:0] qtr; // Quarter inside a bit slot
	logic [2:0] bit_cnt; // Bit inside the current byte
	logic byte_sel; // Second data byte in progress
	logic nack_q;
	logic [15:0] rx; // Shift register for the two data bytes
	logic [7:0] addr_byte;
	logic qtr_end; // Last clock of a quarter
	logic slot_end; // Last clock of a bit slot
	logic sample; // SCL high, mid slot
	logic data_scl; // SCL shape of an ordinary bit slot
	logic scl_d;
	logic oe_d;

	assign addr_byte = {req.addr, 1'b1}; // Read bit appended
	assign qtr_end = (cyc == QUARTER_BIT - 1);
	assign slot_end = qtr_end && (qtr == 2'd3);
	assign sample = qtr_end && (qtr == 2'd1);
	assign data_scl = (qtr == 2'd1) || (qtr == 2'd2);

	assign req.ready = (state == MS_IDLE);
	assign req.read_data = rx;
	assign req.nack = nack_q;

	// Bus levels for the current phase and quarter
	always_comb
	begin
		scl_d = 1'b1; // Released when idle
		oe_d = 1'b0;
		case (state)
			MS_START:
			begin
				scl_d = (qtr != 2'd3);
				oe_d = (qtr != 2'd0); // SDA falls with SCL high
			end
			MS_ADDR:
			begin
				scl_d = data_scl;
				oe_d = !addr_byte[3'd7 - bit_cnt]; // MSB first
			end
			MS_AACK, MS_RDATA:
			begin
				scl_d = data_scl; // SDA left to the slave
			end
			MS_MACK:
			begin
				scl_d = data_scl;
				oe_d = !byte_sel; // ACK first byte, NACK the last
			end
			MS_STOP:
			begin
				scl_d = (qtr != 2'd0);
				oe_d = !qtr[1]; // SDA rises with SCL high
			end
			default:
			begin
				scl_d = 1'b1;
				oe_d = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (sample && state == MS_RDATA)
			rx <= {rx[14:0], sda_in}; // Slave drives MSB first
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= MS_IDLE;
			cyc <= '0;
			qtr <= 2'd0;
			bit_cnt <= 3'd0;
			byte_sel <= 1'b0;
			nack_q <= 1'b0;
			scl <= 1'b1;
			sda_oe <= 1'b0;
		end
		else
		begin
			scl <= scl_d; // Registered to keep the bus glitch free
			sda_oe <= oe_d;
			if (state == MS_IDLE)
			begin
				if (req.start)
				begin
					state <= MS_START;
					cyc <= '0;
					qtr <= 2'd0;
					bit_cnt <= 3'd0;
					byte_sel <= 1'b0;
					nack_q <= 1'b0; // Fresh status per transaction
				end
			end
			else
			begin
				cyc <= qtr_end ? '0 : cyc + 1'b1;
				if (qtr_end)
					qtr <= qtr + 2'd1;
				if (sample && state == MS_AACK)
					nack_q <= sda_in; // Released line means no slave
				if (slot_end)
				begin
					case (state)
						MS_START: state <= MS_ADDR;
						MS_ADDR:
						begin
							bit_cnt <= bit_cnt + 3'd1; // Wraps to 0 after bit 7
							if (bit_cnt == 3'd7)
								state <= MS_AACK;
						end
						MS_AACK: state <= nack_q ? MS_STOP : MS_RDATA; // Skip data on NACK
						MS_RDATA:
						begin
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
								state <= MS_MACK;
						end
						MS_MACK:
						begin
							byte_sel <= 1'b1;
							state <= byte_sel ? MS_STOP : MS_RDATA;
						end
						default: state <= MS_IDLE; // Stop done, ready rises
					endcase
				end
			end
		end
	end

	// Requests arrive only between transactions
	assert property (@(posedge clk) disable iff (rst)
		req.start |-> (state == MS_IDLE));

	// SDA moves under a high SCL only to form start or stop
	assert property (@(posedge clk) disable iff (rst)
		(scl && $past(scl) && $changed(sda_oe)) |-> (state == MS_START || state == MS_STOP));

endmodule

// File: common/i2c_req_if.sv
`timescale 1ns/1ps

interface i2c_req_if;

	logic start; // One-cycle request pulse
	logic [6:0] addr; // Target address, stable while busy
	logic ready; // Master idle
	logic [15:0] read_data; // First byte in the upper half
	logic nack; // Address was not acknowledged

	modport poller (
		output start, addr,
		input ready, read_data, nack
	);

	modport master (
		input start, addr,
		output ready, read_data, nack
	);

endinterface

// File: common/sensor_pkg.sv
package sensor_pkg;

	localparam int NUM_SENSORS = 8; // Sensors polled per sweep
	localparam int NUM_TEMP = 4; // Indices below this are temperature sensors
	localparam int QUARTER_BIT = 4; // Clocks per quarter SCL period

	typedef logic [2:0] poll_idx_t; // Position in the poll order

	// 7-bit bus addresses, index 0 is polled first
	localparam logic [NUM_SENSORS-1:0][6:0] sensor_addr = {
		7'h47, // West light
		7'h46, // South light
		7'h45, // East light
		7'h44, // North light
		7'h4B, // Geothermal temp
		7'h4A, // Ambient temp
		7'h49, // Greenhouse temp
		7'h48  // Solar temp
	};

	// I2C master bus phases
	localparam logic [2:0] MS_IDLE = 3'd0; // Bus free, ready high
	localparam logic [2:0] MS_START = 3'd1; // Start condition slot
	localparam logic [2:0] MS_ADDR = 3'd2; // Address byte plus read bit
	localparam logic [2:0] MS_AACK = 3'd3; // Slave address acknowledge
	localparam logic [2:0] MS_RDATA = 3'd4; // Data byte from slave
	localparam logic [2:0] MS_MACK = 3'd5; // Master ACK or final NACK
	localparam logic [2:0] MS_STOP = 3'd6; // Stop condition slot

	// One raw sensor word, read either as temperature or as light
	typedef union packed {
		struct packed {
			logic signed [8:0] celsius; // Half degree units
			logic [6:0] frac; // Finer bits, unused by the hub
		} temp;
		struct packed {
			logic [3:0] exponent; // Range scaling, power of two
			logic [11:0] mantissa; // Counts of 0.01 lux before scaling
		} light;
	} sensor_word_u;

endpackage
